/* verilog/cart_pkg.sv */
// cartridge loader package with the shared widths, enums, header locations and chip codes
`default_nettype none

package cart_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    typedef logic [24:0] dl_addr_t;
    typedef logic [15:0] dl_word_t;
    typedef logic [7:0]  hdr_byte_t;
    typedef logic [3:0]  size_code_t;
    typedef logic [7:0]  rom_type_t;
    typedef logic [23:0] mem_mask_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [1:0]  wb_addr_t;

    typedef enum logic [1:0] {
        MAP_AUTO    = 2'd0,
        MAP_LOROM   = 2'd1,
        MAP_HIROM   = 2'd2,
        MAP_EXHIROM = 2'd3
    } map_mode_e;

    typedef enum logic [1:0] {
        BASE_LO   = 2'd0,
        BASE_HI   = 2'd1,
        BASE_EXHI = 2'd2
    } base_map_e;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_LOADING,
        DEC_SETTLE,
        DEC_READY
    } decode_state_e;

    // ----------------------------------------
    // internal header locations
    // ----------------------------------------
    parameter logic [23:0] HDR_LO_BASE   = 24'h007FD4;
    parameter logic [23:0] HDR_HI_BASE   = 24'h00FFD4;
    parameter logic [23:0] HDR_EXHI_BASE = 24'h40FFD4;
    // four 16-bit words from the base
    parameter int HDR_SPAN = 8;

    // word index within the header window
    parameter logic [1:0] FLD_MAPPER  = 2'd0;
    parameter logic [1:0] FLD_SIZES   = 2'd1;
    parameter logic [1:0] FLD_RAM     = 2'd2;
    parameter logic [1:0] FLD_COMPANY = 2'd3;

    parameter hdr_byte_t LO_MAPPERS [3] = '{8'h20, 8'h30, 8'h32};

    // ----------------------------------------
    // size codes and chip codes
    // ----------------------------------------
    parameter size_code_t MIN_ROM_CODE      = 4'd7;
    parameter size_code_t ROM_DEFAULT_CODE  = 4'd12;
    parameter size_code_t GSU_RAM_CODE      = 4'd6;
    parameter size_code_t ST_SMALL_ROM_CODE = 4'd10;
    parameter mem_mask_t  KB_UNIT           = 24'd1024;

    // values for rom_type bits 7:4
    parameter logic [3:0] CHIP_DSP1 = 4'h8;
    parameter logic [3:0] CHIP_DSP2 = 4'h9;
    parameter logic [3:0] CHIP_DSP3 = 4'hA;
    parameter logic [3:0] CHIP_DSP4 = 4'hB;
    parameter logic [3:0] CHIP_OBC1 = 4'hC;
    parameter logic [3:0] CHIP_SDD1 = 4'h5;
    parameter logic [3:0] CHIP_SA1  = 4'h6;
    parameter logic [3:0] CHIP_GSU  = 4'h7;
    // ST0xx works on bits 7:3
    parameter logic [4:0] CHIP_ST0XX     = 5'b10001;
    parameter logic [4:0] ST_SMALL_ROM_B = 5'b00100;

    // register word addresses
    parameter wb_addr_t REG_CTRL     = 2'd0;
    parameter wb_addr_t REG_STATUS   = 2'd1;
    parameter wb_addr_t REG_ROM_MASK = 2'd2;
    parameter wb_addr_t REG_RAM_MASK = 2'd3;

endpackage

`default_nettype wire

/* verilog/cart_header_if.sv */
// header field bundle passed from the capture block to the chip decoder
`default_nettype none

interface cart_header_if;
    import cart_pkg::*;

    hdr_byte_t  mapper;
    hdr_byte_t  chip;
    hdr_byte_t  company;
    size_code_t rom_size;
    size_code_t ram_size;
    base_map_e  base_map;

    modport capture (
        output mapper,
        output chip,
        output company,
        output rom_size,
        output ram_size,
        output base_map
    );

    modport decode (
        input mapper,
        input chip,
        input company,
        input rom_size,
        input ram_size,
        input base_map
    );

endinterface

`default_nettype wire

/* verilog/cart_header_capture.sv */
// header capture, strips the copier header from download addresses and grabs header bytes
`default_nettype none

module cart_header_capture #(
    parameter int SMC_HDR_BITS = 10
) (
    input  wire                        clk_sys,
    input  wire                        reset,
    input  wire                        dl_active_i,
    input  wire                        dl_wr_i,
    input  wire cart_pkg::dl_addr_t    dl_addr_i,
    input  wire cart_pkg::dl_word_t    dl_data_i,
    input  wire [31:0]                 dl_filesize_i,
    input  wire cart_pkg::map_mode_e   map_mode_i,
    cart_header_if.capture             hdr
);
    import cart_pkg::*;

    dl_addr_t   addr_adj;
    dl_addr_t   rel_lo;
    dl_addr_t   rel_hi;
    dl_addr_t   rel_exhi;
    logic       accept;
    logic       first_q;
    logic       lo_now;
    logic       use_lo;
    logic       use_hi;
    logic       use_exhi;
    logic       hit;
    logic [1:0] fld;
    hdr_byte_t  mapper_nxt;

    function automatic logic is_lo_mapper(input hdr_byte_t m);
        return (m == LO_MAPPERS[0]) || (m == LO_MAPPERS[1]) || (m == LO_MAPPERS[2]);
    endfunction

    assign accept = dl_active_i && dl_wr_i;

    // copier header length sits in the low filesize bits
    assign addr_adj = dl_addr_i - dl_addr_t'(dl_filesize_i[SMC_HDR_BITS-1:0]);

    assign rel_lo   = addr_adj - dl_addr_t'(HDR_LO_BASE);
    assign rel_hi   = addr_adj - dl_addr_t'(HDR_HI_BASE);
    assign rel_exhi = addr_adj - dl_addr_t'(HDR_EXHI_BASE);

    // ----------------------------------------
    // which header windows are open
    // ----------------------------------------
    always_comb begin
        lo_now   = !first_q && is_lo_mapper(hdr.mapper);
        use_lo   = 1'b0;
        use_hi   = 1'b0;
        use_exhi = 1'b0;
        case (map_mode_i)
            MAP_AUTO: begin
                // HiROM stays open until a LoROM mapper byte shows up
                use_lo = 1'b1;
                use_hi = !lo_now;
            end
            MAP_LOROM: use_lo = 1'b1;
            MAP_HIROM: use_hi = 1'b1;
            default:   use_exhi = 1'b1;
        endcase
    end

    always_comb begin
        hit = 1'b0;
        fld = FLD_MAPPER;
        if (use_lo && rel_lo < dl_addr_t'(HDR_SPAN)) begin
            hit = 1'b1;
            fld = rel_lo[2:1];
        end
        if (use_hi && rel_hi < dl_addr_t'(HDR_SPAN)) begin
            hit = 1'b1;
            fld = rel_hi[2:1];
        end
        if (use_exhi && rel_exhi < dl_addr_t'(HDR_SPAN)) begin
            hit = 1'b1;
            fld = rel_exhi[2:1];
        end
    end

    // stale mapper from an earlier image must not block auto detection
    always_comb begin
        mapper_nxt = first_q ? '0 : hdr.mapper;
        if (hit && fld == FLD_MAPPER) begin
            mapper_nxt = dl_data_i[15:8];
        end
    end

    // ----------------------------------------
    // header field registers
    // ----------------------------------------
    always_ff @(posedge clk_sys) begin
        if (accept) begin
            hdr.mapper <= mapper_nxt;
            if (first_q) begin
                hdr.ram_size <= '0;
            end
            if (hit) begin
                case (fld)
                    FLD_SIZES: begin
                        hdr.rom_size <= dl_data_i[11:8];
                        hdr.chip     <= dl_data_i[7:0];
                    end
                    FLD_RAM:     hdr.ram_size <= dl_data_i[3:0];
                    FLD_COMPANY: hdr.company  <= dl_data_i[7:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            first_q      <= 1'b1;
            hdr.base_map <= BASE_LO;
        end else begin
            // rearm between downloads
            if (!dl_active_i) begin
                first_q <= 1'b1;
            end else if (dl_wr_i) begin
                first_q <= 1'b0;
            end
            if (accept) begin
                case (map_mode_i)
                    MAP_AUTO:  hdr.base_map <= is_lo_mapper(mapper_nxt) ? BASE_LO : BASE_HI;
                    MAP_LOROM: hdr.base_map <= BASE_LO;
                    MAP_HIROM: hdr.base_map <= BASE_HI;
                    default:   hdr.base_map <= BASE_EXHI;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/cart_chip_decode.sv */
// chip decoder, classifies the coprocessor and builds the rom and save-ram masks
`default_nettype none

module cart_chip_decode (
    input  wire                  clk_sys,
    input  wire                  reset,
    input  wire                  dl_active_i,
    input  wire                  video_region_i,
    cart_header_if.decode        hdr,
    output cart_pkg::rom_type_t  rom_type_o,
    output cart_pkg::mem_mask_t  rom_mask_o,
    output cart_pkg::mem_mask_t  ram_mask_o,
    output logic                 pal_o,
    output logic                 cart_ready_o
);
    import cart_pkg::*;

    decode_state_e state_q;
    decode_state_e state_d;
    logic [4:0]    chip_code;
    logic          is_gsu;
    size_code_t    rom_code;
    mem_mask_t     rom_mask_d;
    mem_mask_t     ram_mask_d;

    function automatic mem_mask_t size_mask(input size_code_t code);
        return (KB_UNIT << code) - mem_mask_t'(1);
    endfunction

    // ----------------------------------------
    // download tracking
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            DEC_IDLE: begin
                if (dl_active_i) begin
                    state_d = DEC_LOADING;
                end
            end
            DEC_LOADING: begin
                if (!dl_active_i) begin
                    state_d = DEC_SETTLE;
                end
            end
            DEC_SETTLE: begin
                state_d = dl_active_i ? DEC_LOADING : DEC_READY;
            end
            default: begin
                if (dl_active_i) begin
                    state_d = DEC_LOADING;
                end
            end
        endcase
    end

    assign cart_ready_o = (state_q == DEC_READY);

    // ----------------------------------------
    // coprocessor priority table
    // ----------------------------------------
    always_comb begin
        chip_code = '0;
        is_gsu    = 1'b0;
        if (hdr.mapper == 8'h30 && hdr.chip == 8'h05 && hdr.company == 8'hB2) begin
            chip_code = {CHIP_DSP3, 1'b0};
        end else if (((hdr.mapper == 8'h20 || hdr.mapper == 8'h21) && hdr.chip == 8'h03) ||
                     (hdr.mapper == 8'h30 && hdr.chip == 8'h05) ||
                     (hdr.mapper == 8'h31 && (hdr.chip == 8'h03 || hdr.chip == 8'h05))) begin
            chip_code = {CHIP_DSP1, 1'b0};
        end else if (hdr.mapper == 8'h20 && hdr.chip == 8'h05) begin
            chip_code = {CHIP_DSP2, 1'b0};
        end else if (hdr.mapper == 8'h30 && hdr.chip == 8'h03) begin
            chip_code = {CHIP_DSP4, 1'b0};
        end else if (hdr.mapper == 8'h30 && hdr.chip == 8'h25) begin
            chip_code = {CHIP_OBC1, 1'b0};
        end else if (hdr.mapper == 8'h32 && (hdr.chip == 8'h43 || hdr.chip == 8'h45)) begin
            chip_code = {CHIP_SDD1, 1'b0};
        end else if (hdr.mapper == 8'h30 && hdr.chip == 8'hF6) begin
            chip_code = CHIP_ST0XX;
            // small ST0xx images use the other variant
            if (hdr.rom_size < ST_SMALL_ROM_CODE) begin
                chip_code = chip_code | ST_SMALL_ROM_B;
            end
        end else if (hdr.mapper == 8'h20 && (hdr.chip == 8'h13 || hdr.chip == 8'h14 ||
                                             hdr.chip == 8'h15 || hdr.chip == 8'h1A)) begin
            chip_code = {CHIP_GSU, 1'b0};
            is_gsu    = 1'b1;
        end else if (hdr.mapper == 8'h23 && (hdr.chip == 8'h32 || hdr.chip == 8'h34 ||
                                             hdr.chip == 8'h35)) begin
            chip_code = {CHIP_SA1, 1'b0};
        end
    end

    // undersized rom codes fall back to the 4 MB default
    assign rom_code   = (hdr.rom_size < MIN_ROM_CODE) ? ROM_DEFAULT_CODE : hdr.rom_size;
    assign rom_mask_d = size_mask(rom_code);

    always_comb begin
        if (is_gsu) begin
            ram_mask_d = size_mask(GSU_RAM_CODE);
        end else if (hdr.ram_size == '0) begin
            ram_mask_d = '0;
        end else begin
            ram_mask_d = size_mask(hdr.ram_size);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state_q    <= DEC_IDLE;
            rom_type_o <= '0;
            rom_mask_o <= '0;
            ram_mask_o <= '0;
            pal_o      <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == DEC_SETTLE) begin
                rom_type_o <= {chip_code, 1'b0, hdr.base_map};
                rom_mask_o <= rom_mask_d;
                ram_mask_o <= ram_mask_d;
                pal_o      <= video_region_i;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/cart_cfg_regs.sv */
// wishbone classic register block for map mode, video region and loader results
`default_nettype none

module cart_cfg_regs (
    input  wire                       clk_sys,
    input  wire                       reset,
    input  wire                       wb_cyc_i,
    input  wire                       wb_stb_i,
    input  wire                       wb_we_i,
    input  wire cart_pkg::wb_addr_t   wb_adr_i,
    input  wire cart_pkg::wb_data_t   wb_dat_i,
    output cart_pkg::wb_data_t        wb_dat_o,
    output logic                      wb_ack_o,
    output cart_pkg::map_mode_e       map_mode_o,
    output logic                      video_region_o,
    input  wire cart_pkg::rom_type_t  rom_type_i,
    input  wire cart_pkg::mem_mask_t  rom_mask_i,
    input  wire cart_pkg::mem_mask_t  ram_mask_i,
    input  wire                       cart_ready_i
);
    import cart_pkg::*;

    logic     wb_hit;
    wb_data_t rd_data;

    // new access only while no ack is pending
    assign wb_hit = wb_cyc_i && wb_stb_i && !wb_ack_o;

    // ----------------------------------------
    // read-back mux
    // ----------------------------------------
    always_comb begin
        case (wb_adr_i)
            REG_CTRL:     rd_data = {29'd0, video_region_o, map_mode_o};
            REG_STATUS:   rd_data = {23'd0, cart_ready_i, rom_type_i};
            REG_ROM_MASK: rd_data = {8'd0, rom_mask_i};
            default:      rd_data = {8'd0, ram_mask_i};
        endcase
    end

    // ----------------------------------------
    // ack and CTRL
    // ----------------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wb_ack_o       <= 1'b0;
            map_mode_o     <= MAP_AUTO;
            video_region_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_hit;
            // the other registers ignore writes
            if (wb_hit && wb_we_i && wb_adr_i == REG_CTRL) begin
                map_mode_o     <= map_mode_e'(wb_dat_i[1:0]);
                video_region_o <= wb_dat_i[2];
            end
        end
    end

    // data held for the ack cycle
    always_ff @(posedge clk_sys) begin
        if (wb_hit) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/cart_loader_top.sv */
// cartridge loader top level, header capture, chip decode and register block
`default_nettype none

module cart_loader_top #(
    parameter int SMC_HDR_BITS = 10
) (
    input  wire                       clk_sys,
    input  wire                       reset,

    // rom download stream
    input  wire                       dl_active_i,
    input  wire                       dl_wr_i,
    input  wire cart_pkg::dl_addr_t   dl_addr_i,
    input  wire cart_pkg::dl_word_t   dl_data_i,
    input  wire [31:0]                dl_filesize_i,

    // wishbone register port
    input  wire                       wb_cyc_i,
    input  wire                       wb_stb_i,
    input  wire                       wb_we_i,
    input  wire cart_pkg::wb_addr_t   wb_adr_i,
    input  wire cart_pkg::wb_data_t   wb_dat_i,
    output cart_pkg::wb_data_t        wb_dat_o,
    output logic                      wb_ack_o,

    // results
    output cart_pkg::rom_type_t       rom_type_o,
    output cart_pkg::mem_mask_t       rom_mask_o,
    output cart_pkg::mem_mask_t       ram_mask_o,
    output logic                      pal_o,
    output logic                      cart_ready_o
);
    import cart_pkg::*;

    map_mode_e map_mode;
    logic      video_region;

    cart_header_if u_hdr_if ();

    cart_header_capture #(
        .SMC_HDR_BITS (SMC_HDR_BITS)
    ) u_capture (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .dl_active_i   (dl_active_i),
        .dl_wr_i       (dl_wr_i),
        .dl_addr_i     (dl_addr_i),
        .dl_data_i     (dl_data_i),
        .dl_filesize_i (dl_filesize_i),
        .map_mode_i    (map_mode),
        .hdr           (u_hdr_if.capture)
    );

    cart_chip_decode u_decode (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .dl_active_i    (dl_active_i),
        .video_region_i (video_region),
        .hdr            (u_hdr_if.decode),
        .rom_type_o     (rom_type_o),
        .rom_mask_o     (rom_mask_o),
        .ram_mask_o     (ram_mask_o),
        .pal_o          (pal_o),
        .cart_ready_o   (cart_ready_o)
    );

    cart_cfg_regs u_regs (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .map_mode_o     (map_mode),
        .video_region_o (video_region),
        .rom_type_i     (rom_type_o),
        .rom_mask_i     (rom_mask_o),
        .ram_mask_i     (ram_mask_o),
        .cart_ready_i   (cart_ready_o)
    );

endmodule

`default_nettype wire

/* verification/cart_loader_sva.sv */
// cartridge loader checker for wishbone ack timing and ready during a download
`default_nettype none

module cart_loader_sva (
    input wire clk_sys,
    input wire reset,
    input wire wb_cyc_i,
    input wire wb_stb_i,
    input wire wb_ack_i,
    input wire dl_active_i,
    input wire cart_ready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // count of failed assertions
    int fail_count = 0;

    ack_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
        wb_ack_i |=> !wb_ack_i)
    else begin
        $error("wishbone ack held for more than one cycle");
        fail_count++;
    end

    ack_after_request: assert property (@(posedge clk_sys) disable iff (reset)
        wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
    else begin
        $error("wishbone ack without a cycle and strobe before it");
        fail_count++;
    end

    // ready drops one edge after the download starts
    ready_low_in_download: assert property (@(posedge clk_sys) disable iff (reset)
        dl_active_i && $past(dl_active_i) |-> !cart_ready_i)
    else begin
        $error("cart ready high while a download is active");
        fail_count++;
    end

endmodule

bind cart_loader_top cart_loader_sva u_sva (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_ack_i     (wb_ack_o),
    .dl_active_i  (dl_active_i),
    .cart_ready_i (cart_ready_o)
);

`default_nettype wire

/* verification/tb_cart_loader.sv */
// cartridge loader testbench that streams header images and checks decode results and registers
`default_nettype none

module tb_cart_loader;
    timeunit 1ns;
    timeprecision 1ps;

    import cart_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_ROWS      = 6;
    localparam int NUM_FILL      = 8;
    localparam int WORDS_PER_ROW = NUM_FILL + 8;
    localparam int ROW_MARGIN    = 64;
    localparam int ACK_LIMIT     = 16;
    localparam int WATCHDOG_NS   =
        (NUM_ROWS + 1) * (2 * WORDS_PER_ROW + ROW_MARGIN) * CLK_PERIOD;

    typedef struct packed {
        map_mode_e  mode;
        logic [9:0] hdr_len;
        hdr_byte_t  mapper;
        hdr_byte_t  chip;
        size_code_t rom_code;
        size_code_t ram_code;
        hdr_byte_t  company;
        logic       region;
        rom_type_t  exp_type;
        mem_mask_t  exp_rom_mask;
        mem_mask_t  exp_ram_mask;
    } row_t;

    // ----------------------------------------
    // mode, copier, mapper, chip, rom, ram, company, region, type, rom mask, ram mask
    // ----------------------------------------
    localparam row_t ROWS [NUM_ROWS] = '{
        '{MAP_AUTO,    10'd0,   8'h20, 8'h00, 4'hA, 4'h3, 8'h01, 1'b0,
          8'h00, 24'h0FFFFF, 24'h001FFF},
        '{MAP_AUTO,    10'd512, 8'h21, 8'h03, 4'h5, 4'h0, 8'h01, 1'b1,
          8'h81, 24'h3FFFFF, 24'h000000},
        '{MAP_EXHIROM, 10'd0,   8'h25, 8'h00, 4'hD, 4'h0, 8'h01, 1'b0,
          8'h02, 24'h7FFFFF, 24'h000000},
        '{MAP_AUTO,    10'd512, 8'h20, 8'h15, 4'hA, 4'h5, 8'h01, 1'b1,
          8'h70, 24'h0FFFFF, 24'h00FFFF},
        '{MAP_LOROM,   10'd0,   8'h23, 8'h34, 4'hB, 4'h2, 8'h01, 1'b0,
          8'h60, 24'h1FFFFF, 24'h000FFF},
        '{MAP_AUTO,    10'd0,   8'h30, 8'hF6, 4'h9, 4'h0, 8'h01, 1'b1,
          8'hA8, 24'h07FFFF, 24'h000000}
    };

    logic        clk_sys;
    logic        reset;
    logic        dl_active;
    logic        dl_wr;
    dl_addr_t    dl_addr;
    dl_word_t    dl_data;
    logic [31:0] dl_filesize;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_addr_t    wb_adr;
    wb_data_t    wb_dat_w;
    wb_data_t    wb_dat_r;
    logic        wb_ack;
    rom_type_t   rom_type;
    mem_mask_t   rom_mask;
    mem_mask_t   ram_mask;
    logic        pal;
    logic        cart_ready;
    integer      seed;
    dl_addr_t    img_addr [$];
    dl_word_t    img_data [$];

    cart_loader_top #(
        .SMC_HDR_BITS (10)
    ) u_dut (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .dl_active_i   (dl_active),
        .dl_wr_i       (dl_wr),
        .dl_addr_i     (dl_addr),
        .dl_data_i     (dl_data),
        .dl_filesize_i (dl_filesize),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat_w),
        .wb_dat_o      (wb_dat_r),
        .wb_ack_o      (wb_ack),
        .rom_type_o    (rom_type),
        .rom_mask_o    (rom_mask),
        .ram_mask_o    (ram_mask),
        .pal_o         (pal),
        .cart_ready_o  (cart_ready)
    );

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic expect_type(input string name, input rom_type_t expected,
                               input rom_type_t actual);
        if (actual !== expected) begin
            $display("Error: time %0d ns, %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_mask(input string name, input mem_mask_t expected,
                                input mem_mask_t actual);
        if (actual !== expected) begin
            $display("Error: time %0d ns, %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic verify_word(input string name, input wb_data_t expected,
                               input wb_data_t actual);
        if (actual !== expected) begin
            $display("Error: time %0d ns, %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic match_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: time %0d ns, %s expected %b, got %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // wishbone master
    // ----------------------------------------
    task automatic await_ack();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_sys);
            cycles++;
        end while (!wb_ack && cycles < ACK_LIMIT);
        if (!wb_ack) begin
            $display("Error: no Wishbone ack within %0d cycles at %0d ns", ACK_LIMIT, $time);
            abort_run();
        end
    endtask

    task automatic write_register(input wb_addr_t adr, input wb_data_t dat);
        @(negedge clk_sys);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        await_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_register(input wb_addr_t adr, input string name, input wb_data_t exp);
        wb_data_t dat;
        @(negedge clk_sys);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        await_ack();
        dat    = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        verify_word(name, exp, dat);
    endtask

    // ----------------------------------------
    // download image
    // ----------------------------------------
    function automatic dl_addr_t header_base(input row_t r);
        case (r.mode)
            MAP_LOROM:   return dl_addr_t'(HDR_LO_BASE);
            MAP_HIROM:   return dl_addr_t'(HDR_HI_BASE);
            MAP_EXHIROM: return dl_addr_t'(HDR_EXHI_BASE);
            default: begin
                if (r.mapper == 8'h20 || r.mapper == 8'h30 || r.mapper == 8'h32) begin
                    return dl_addr_t'(HDR_LO_BASE);
                end
                return dl_addr_t'(HDR_HI_BASE);
            end
        endcase
    endfunction

    task automatic push_header(input dl_addr_t base, input hdr_byte_t mapper,
                               input hdr_byte_t chip, input size_code_t rom_code,
                               input size_code_t ram_code, input hdr_byte_t company);
        img_addr.push_back(base);
        img_data.push_back({mapper, 8'h00});
        img_addr.push_back(base + dl_addr_t'(2));
        img_data.push_back({4'h0, rom_code, chip});
        img_addr.push_back(base + dl_addr_t'(4));
        img_data.push_back({12'h000, ram_code});
        img_addr.push_back(base + dl_addr_t'(6));
        img_data.push_back({8'h00, company});
    endtask

    task automatic build_image(input row_t r);
        dl_addr_t skew;
        int       k;
        img_addr.delete();
        img_data.delete();
        skew = dl_addr_t'(r.hdr_len);
        // filler far from all three header windows
        for (k = 0; k < NUM_FILL; k++) begin
            img_addr.push_back(skew + dl_addr_t'(32'h100 + k * 32'h2000));
            img_data.push_back(dl_word_t'($random(seed)));
        end
        push_header(skew + header_base(r), r.mapper, r.chip, r.rom_code, r.ram_code,
                    r.company);
        // decoy LoROM header last so that a wrong capture would overwrite the fields
        if (r.mode == MAP_EXHIROM) begin
            push_header(skew + dl_addr_t'(HDR_LO_BASE), 8'h20, 8'h03, 4'h8, 4'h5, 8'h33);
        end
    endtask

    task automatic run_download(input row_t r);
        int idx;
        build_image(r);
        @(negedge clk_sys);
        dl_filesize = 32'h0050_0000 + 32'(r.hdr_len);
        dl_active   = 1'b1;
        @(negedge clk_sys);
        match_bit("cart_ready_o", 1'b0, cart_ready);
        for (idx = 0; idx < img_addr.size(); idx++) begin
            dl_wr   = 1'b1;
            dl_addr = img_addr[idx];
            dl_data = img_data[idx];
            @(negedge clk_sys);
        end
        dl_wr     = 1'b0;
        dl_active = 1'b0;
        // one settle cycle before ready
        @(negedge clk_sys);
        match_bit("cart_ready_o", 1'b0, cart_ready);
        @(negedge clk_sys);
        match_bit("cart_ready_o", 1'b1, cart_ready);
    endtask

    task automatic inspect_results(input row_t r);
        expect_type("rom_type_o", r.exp_type, rom_type);
        compare_mask("rom_mask_o", r.exp_rom_mask, rom_mask);
        compare_mask("ram_mask_o", r.exp_ram_mask, ram_mask);
        match_bit("pal_o", r.region, pal);
        read_register(REG_STATUS, "STATUS", wb_data_t'({1'b1, r.exp_type}));
        read_register(REG_ROM_MASK, "ROM_MASK", wb_data_t'(r.exp_rom_mask));
        read_register(REG_RAM_MASK, "RAM_MASK", wb_data_t'(r.exp_ram_mask));
        read_register(REG_CTRL, "CTRL", wb_data_t'({r.region, r.mode}));
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        int row;
        seed        = 32'h58e342fe;
        reset       = 1'b1;
        dl_active   = 1'b0;
        dl_wr       = 1'b0;
        dl_addr     = '0;
        dl_data     = '0;
        dl_filesize = '0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;

        // everything cleared by reset
        match_bit("cart_ready_o", 1'b0, cart_ready);
        match_bit("pal_o", 1'b0, pal);
        read_register(REG_CTRL, "CTRL", '0);
        read_register(REG_STATUS, "STATUS", '0);
        read_register(REG_ROM_MASK, "ROM_MASK", '0);
        read_register(REG_RAM_MASK, "RAM_MASK", '0);
        write_register(REG_CTRL, 32'h5);
        read_register(REG_CTRL, "CTRL", 32'h5);
        write_register(REG_ROM_MASK, 32'hFFFF_FFFF);
        read_register(REG_ROM_MASK, "ROM_MASK", '0);

        for (row = 0; row < NUM_ROWS; row++) begin
            write_register(REG_CTRL, wb_data_t'({ROWS[row].region, ROWS[row].mode}));
            run_download(ROWS[row]);
            inspect_results(ROWS[row]);
        end

        if (u_dut.u_sva.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Error: %0d assertion failures seen", u_dut.u_sva.fail_count);
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
verilog/cart_pkg.sv
verilog/cart_header_if.sv
verilog/cart_header_capture.sv
verilog/cart_chip_decode.sv
verilog/cart_cfg_regs.sv
verilog/cart_loader_top.sv
verification/cart_loader_sva.sv
verification/tb_cart_loader.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cartridge loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cart_loader -f vlog.f \
    -Mdir "$BUILD_DIR" -o tb_cart_loader
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_cart_loader" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG_FILE"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
